//--- test/multih_traceback_trace.txt
# name  sel (128-bit hex, state 63 first)  best_state (hex)  sym_even  gap (cycles)  expected (hex)
# random lines take sel and best_state from the LCG and carry f as expected value
zero_hist0   ffffffffffffffffffffffffffffffff  2a  0  6   0
zero_hist1   e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4  11  1  8   0
zero_hist2   aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa  3f  0  5   0
age_u3       55555555555555555555555555555555  05  1  5   3
walk_even    00000000000000000000000000000000  27  0  5   2
age_u2       ffffffffaaaaaaaa5555555500000000  30  1  5   2
age_u1       ffaa5500ffaa5500ffaa5500ffaa5500  1c  0  40  1
age_zero     e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4  0e  1  5   0
walk_odd     ffffffffffffffffffffffffffffffff  1d  1  5   3
parity_even  ffffffffaaaaaaaa5555555500000000  2b  0  5   3
parity_odd   ffaa5500ffaa5500ffaa5500ffaa5500  2b  1  7   3
age_u3b      e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4  3c  0  5   3
b2b_a        e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4e4  16  1  5   1
b2b_b        ffaa5500ffaa5500ffaa5500ffaa5500  09  0  5   0
idle_gap_a   ffffffffaaaaaaaa5555555500000000  35  1  30  2
idle_gap_b   aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa  00  0  5   2
random       0  00  0  5   f
random       0  00  1  5   f
random       0  00  1  6   f
random       0  00  0  9   f
random       0  00  1  5   f
random       0  00  0  5   f
random       0  00  0  7   f
random       0  00  1  5   f
random       0  00  0  12  f
random       0  00  1  5   f
random       0  00  0  5   f
random       0  00  1  8   f
random       0  00  0  5   f
random       0  00  1  5   f

//--- multih_traceback.f
+incdir+rtl
rtl/trellis_pkg.sv
rtl/trace_ctrl_pkg.sv
rtl/trace_sequencer.sv
rtl/survivor_history.sv
rtl/trace_walker.sv
rtl/multih_traceback.sv
test/multih_traceback_tb.sv

//--- Makefile
# Verilator flow for the multi-h trace-back unit

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module multih_traceback_tb -f multih_traceback.f

run: compile
	./obj_dir/Vmultih_traceback_tb | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/multih_traceback_tb.sv
`timescale 1ns/1ps
`include "trellis_config.svh"

module multih_traceback_tb;
   import trellis_pkg::*;

   logic            clk = 1'b0;
   logic            reset;
   logic            sym_en;
   logic            sym_even;
   survivor_row_t   sel;
   state_idx_t      best_state;
   branch_dec_t     decision;
   logic            dec_valid;

   // trace contents, one entry per symbol
   string           names[$];
   logic [127:0]    sels[$];
   state_idx_t      bests[$];
   bit              evens[$];
   int              gaps[$];
   logic [3:0]      exps[$];    // f means model only

   // decisions in flight, oldest first
   branch_dec_t     pend_dec[$];
   int              pend_cycle[$];
   int              pend_idx[$];

   survivor_row_t   ref_hist [`TB_DEPTH];   // ref_hist[0] is the newest row
   logic [31:0]     lcg_state = 32'h8349_83d8;
   int              cycle_count = 0;
   int              value_errors = 0;
   int              timing_errors = 0;
   int              other_errors = 0;
   int              checked = 0;
   int unsigned     timeout_ns = 0;
   bit              trace_loaded = 1'b0;
   bit              prev_valid = 1'b0;

   multih_traceback multih_traceback_inst (
      .clk        (clk),
      .reset      (reset),
      .sym_en     (sym_en),
      .sym_even   (sym_even),
      .sel        (sel),
      .best_state (best_state),
      .decision   (decision),
      .dec_valid  (dec_valid)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // low bits take the branch, high nibble steps back by h times the branch
   function automatic state_idx_t step_back(input state_idx_t cur, input branch_dec_t dec,
                                            input bit odd);
      logic [3:0] h;
      logic [3:0] hi;
      h  = odd ? 4'(`H_STEP_ODD) : 4'(`H_STEP_EVEN);
      hi = cur[5:2] - h * {2'b00, dec};   // wraps mod 16
      return {hi, dec};
   endfunction

   function automatic branch_dec_t model_walk(input survivor_row_t live, input state_idx_t best,
                                              input bit even);
      state_idx_t  cur;
      branch_dec_t dec;
      bit          odd;
      int          r;
      cur = best;
      dec = live[best];   // first selection comes from the live row
      odd = even;
      for (r = 0; r < `TB_DEPTH; r++) begin
         cur = step_back(cur, dec, odd);
         dec = ref_hist[r][cur];
         odd = ~odd;
      end
      return dec;
   endfunction

   task automatic shift_history(input survivor_row_t row);
      int r;
      for (r = `TB_DEPTH - 1; r > 0; r--) begin
         ref_hist[r] = ref_hist[r-1];
      end
      ref_hist[0] = row;
   endtask

   // ------------------------------------------------------------
   // trace reader and symbol driver
   // ------------------------------------------------------------
   task automatic load_trace;
      int           fd;
      int           n;
      int           max_gap;
      string        text_line;
      string        name;
      logic [127:0] sel_v;
      state_idx_t   best_v;
      int           even_v;
      int           gap_v;
      logic [3:0]   exp_v;
      max_gap = 5;
      fd = $fopen("test/multih_traceback_trace.txt", "r");
      if (fd == 0) begin
         $display("cannot open the trace file");
         other_errors++;
      end else begin
         while ($fgets(text_line, fd) > 0) begin
            if (text_line.len() < 2 || text_line.getc(0) == "#") begin
               continue;
            end
            n = $sscanf(text_line, "%s %h %h %d %d %h", name, sel_v, best_v, even_v,
                        gap_v, exp_v);
            if (n != 6 || gap_v < 5) begin
               $display("malformed trace line: %s", text_line);
               other_errors++;
            end else begin
               names.push_back(name);
               sels.push_back(sel_v);
               bests.push_back(best_v);
               evens.push_back(even_v[0]);
               gaps.push_back(gap_v);
               exps.push_back(exp_v);
               if (gap_v > max_gap) begin
                  max_gap = gap_v;
               end
            end
         end
         $fclose(fd);
         if (names.size() == 0) begin
            $display("the trace file holds no symbols");
            other_errors++;
         end
      end
      timeout_ns = names.size() * (max_gap + 5) * 20 + 1000;   // margin covers reset
      trace_loaded = 1'b1;
   endtask

   task automatic drive_symbol(input int idx);
      logic [127:0]  raw;
      survivor_row_t row;
      state_idx_t    best;
      branch_dec_t   want;
      int            w;
      if (names[idx] == "random") begin
         for (w = 0; w < 4; w++) begin
            lcg_state = lcg_next(lcg_state);
            raw[32*w +: 32] = lcg_state;
         end
         lcg_state = lcg_next(lcg_state);
         best = lcg_state[31:26];   // upper bits, the low ones cycle fast
      end else begin
         raw  = sels[idx];
         best = bests[idx];
      end
      row  = raw;
      want = model_walk(row, best, evens[idx]);
      if (exps[idx] != 4'hf && exps[idx] != {2'b00, want}) begin
         $display("FAILED %s (symbol %0d) trace column: expected %0d, actual %0d",
                  names[idx], idx, exps[idx], want);
         value_errors++;
      end
      shift_history(row);
      @(posedge clk);
      sym_en     <= 1'b1;
      sym_even   <= evens[idx];
      sel        <= row;
      best_state <= best;
      @(negedge clk);
      pend_dec.push_back(want);
      pend_cycle.push_back(cycle_count + 1);   // edge that samples the strobe
      pend_idx.push_back(idx);
      @(posedge clk);
      sym_en <= 1'b0;
      repeat (gaps[idx] - 2) @(posedge clk);
   endtask

   // ------------------------------------------------------------
   // output checker, sampled mid-cycle
   // ------------------------------------------------------------
   always @(negedge clk) begin : check_output
      int          idx;
      int          latency;
      branch_dec_t want;
      if (!reset) begin
         if (dec_valid && prev_valid) begin
            $display("dec_valid held high for two cycles at cycle %0d", cycle_count);
            timing_errors++;
         end
         if (dec_valid) begin
            if (pend_dec.size() == 0) begin
               $display("dec_valid rose with no symbol outstanding at cycle %0d", cycle_count);
               timing_errors++;
            end else begin
               want    = pend_dec.pop_front();
               idx     = pend_idx.pop_front();
               latency = cycle_count - pend_cycle.pop_front();
               checked++;
               if (latency != 4) begin
                  $display("FAILED %s (symbol %0d) latency: expected 4, actual %0d",
                           names[idx], idx, latency);
                  timing_errors++;
               end
               if (decision !== want) begin
                  $display("FAILED %s (symbol %0d) decision: expected %0d, actual %0d",
                           names[idx], idx, want, decision);
                  value_errors++;
               end
            end
         end
      end
      prev_valid = dec_valid;
   end

   // watchdog, armed once the trace length is known
   initial begin
      wait (trace_loaded);
      #(timeout_ns);
      $display("timeout after %0d ns with %0d decisions outstanding", timeout_ns,
               pend_dec.size());
      $display("Test FAILED");
      $finish;
   end

   initial begin : main
      int idx;
      int drain;
      reset      = 1'b1;
      sym_en     = 1'b0;
      sym_even   = 1'b0;
      sel        = '0;
      best_state = '0;
      for (idx = 0; idx < `TB_DEPTH; idx++) begin
         ref_hist[idx] = '0;
      end
      load_trace();
      repeat (3) @(posedge clk);
      reset <= 1'b0;

      // quiet outputs before the first strobe
      repeat (3) begin
         @(negedge clk);
         if (dec_valid !== 1'b0 || decision !== 2'b00) begin
            $display("outputs not idle after reset: dec_valid %b decision %0d",
                     dec_valid, decision);
            other_errors++;
         end
      end

      for (idx = 0; idx < names.size(); idx++) begin
         drive_symbol(idx);
      end

      drain = 0;
      while (pend_dec.size() != 0 && drain < 20) begin
         @(negedge clk);
         drain++;
      end
      if (pend_dec.size() != 0) begin
         $display("%0d decisions never arrived", pend_dec.size());
         other_errors += pend_dec.size();
      end
      @(negedge clk);

      $display("errors: %0d decision, %0d timing, %0d other, %0d decisions checked",
               value_errors, timing_errors, other_errors, checked);
      if (value_errors == 0 && timing_errors == 0 && other_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- rtl/multih_traceback.sv
`timescale 1ns/1ps

module multih_traceback (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          sym_en,
   input  logic                          sym_even,
   input  trellis_pkg::survivor_row_t    sel,
   input  trellis_pkg::state_idx_t       best_state,
   output trellis_pkg::branch_dec_t      decision,
   output logic                          dec_valid
);
   import trellis_pkg::*;
   import trace_ctrl_pkg::*;

   trace_ctrl_t  ctrl;     // phase and index parity
   state_idx_t   rd_addr;
   branch_dec_t  rd_dec;   // same-cycle history read

   trace_sequencer trace_sequencer_inst (
      .clk      (clk),
      .reset    (reset),
      .sym_en   (sym_en),
      .sym_even (sym_even),
      .ctrl     (ctrl)
   );

   survivor_history survivor_history_inst (
      .clk     (clk),
      .reset   (reset),
      .sym_en  (sym_en),
      .sel     (sel),
      .ctrl    (ctrl),
      .rd_addr (rd_addr),
      .rd_dec  (rd_dec)
   );

   trace_walker trace_walker_inst (
      .clk        (clk),
      .reset      (reset),
      .sym_en     (sym_en),
      .best_state (best_state),
      .ctrl       (ctrl),
      .rd_dec     (rd_dec),
      .rd_addr    (rd_addr),
      .decision   (decision),
      .dec_valid  (dec_valid)
   );

endmodule

//--- rtl/trace_walker.sv
`timescale 1ns/1ps
`include "trellis_config.svh"

module trace_walker (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          sym_en,
   input  trellis_pkg::state_idx_t       best_state,
   input  trace_ctrl_pkg::trace_ctrl_t   ctrl,
   input  trellis_pkg::branch_dec_t      rd_dec,
   output trellis_pkg::state_idx_t       rd_addr,
   output trellis_pkg::branch_dec_t      decision,
   output logic                          dec_valid
);
   import trellis_pkg::*;
   import trace_ctrl_pkg::*;

   logic                                  start;
   logic                                  walk_step;
   state_idx_t                            cur_state;
   branch_dec_t                           work_dec;
   state_idx_t                            pred_state;
   logic [`STATE_BITS-`DEC_BITS-1:0]      h_step;
   logic [`STATE_BITS-`DEC_BITS-1:0]      h_sub;

   assign start     = sym_en && (ctrl.phase == PH_IDLE);
   assign walk_step = ctrl.phase inside {PH_ROW0, PH_ROW1, PH_ROW2};

   // ------------------------------------------------------------
   // predecessor arithmetic
   // ------------------------------------------------------------
   // low bits of the predecessor are the branch taken into it,
   // high nibble steps back by h times that branch, mod 16
   always_comb begin
      if (ctrl.h_odd) begin
         h_step = (`STATE_BITS-`DEC_BITS)'(`H_STEP_ODD);
      end else begin
         h_step = (`STATE_BITS-`DEC_BITS)'(`H_STEP_EVEN);
      end
      h_sub = h_step * (`STATE_BITS-`DEC_BITS)'(work_dec);  // wraps mod 16
      pred_state[`DEC_BITS-1:0]            = work_dec;
      pred_state[`STATE_BITS-1:`DEC_BITS]  = cur_state[`STATE_BITS-1:`DEC_BITS] - h_sub;
   end

   // best state looks up the live row, later steps the stored rows
   assign rd_addr = start ? best_state : pred_state;

   // ------------------------------------------------------------
   // walk registers
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (start) begin
         cur_state <= best_state;
         work_dec  <= rd_dec;      // selection of the best state
      end else if (walk_step) begin
         cur_state <= pred_state;  // one symbol further back
         work_dec  <= rd_dec;
      end
   end

   // ------------------------------------------------------------
   // output stage
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         decision  <= '0;
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= (ctrl.phase == PH_COMMIT);  // one cycle per symbol
         if (ctrl.phase == PH_COMMIT) begin
            decision <= work_dec;
         end
      end
   end

   // at most one decision per walk
   a_valid_single: assert property (
      @(posedge clk) disable iff (reset) dec_valid |=> !dec_valid
   ) else $error("dec_valid high for two cycles");

endmodule

//--- rtl/survivor_history.sv
`timescale 1ns/1ps
`include "trellis_config.svh"

module survivor_history (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          sym_en,
   input  trellis_pkg::survivor_row_t    sel,
   input  trace_ctrl_pkg::trace_ctrl_t   ctrl,
   input  trellis_pkg::state_idx_t       rd_addr,
   output trellis_pkg::branch_dec_t      rd_dec
);
   import trellis_pkg::*;
   import trace_ctrl_pkg::*;

   logic                                  start;
   survivor_row_t                         cap_row;  // row of the symbol being walked
   survivor_row_t [`TB_DEPTH-1:0]         hist;     // hist[0] is the newest
   survivor_row_t                         rd_row;

   assign start = sym_en && (ctrl.phase == PH_IDLE);

   // ------------------------------------------------------------
   // capture and history shift
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (start) begin
         cap_row <= sel;
      end
   end

   // captured row enters only after its own walk is done
   always_ff @(posedge clk) begin
      if (reset) begin
         hist <= '0;
      end else if (ctrl.phase == PH_COMMIT) begin
         hist <= {hist[`TB_DEPTH-2:0], cap_row};  // oldest row falls out
      end
   end

   // ------------------------------------------------------------
   // read port
   // ------------------------------------------------------------
   always_comb begin
      case (ctrl.phase)
         PH_ROW0: rd_row = hist[0];
         PH_ROW1: rd_row = hist[1];
         PH_ROW2: rd_row = hist[2];
         default: rd_row = sel;   // live row, used at the strobe
      endcase
   end

   assign rd_dec = rd_row[rd_addr];

   // history may only move right after the walk's COMMIT phase
   a_shift_on_commit: assert property (
      @(posedge clk) disable iff (reset)
      !$stable(hist) |-> $past(ctrl.phase) == PH_COMMIT
   ) else $error("history shifted outside COMMIT");

endmodule

//--- rtl/trace_sequencer.sv
`timescale 1ns/1ps

module trace_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      sym_en,
   input  logic                      sym_even,
   output trace_ctrl_pkg::trace_ctrl_t ctrl
);
   import trace_ctrl_pkg::*;

   trace_phase_t phase;
   trace_phase_t next_phase;
   logic         h_odd;

   // ------------------------------------------------------------
   // phase FSM
   // ------------------------------------------------------------
   always_comb begin
      case (phase)
         PH_IDLE:   next_phase = sym_en ? PH_ROW0 : PH_IDLE;  // late strobes dropped
         PH_ROW0:   next_phase = PH_ROW1;
         PH_ROW1:   next_phase = PH_ROW2;
         PH_ROW2:   next_phase = PH_COMMIT;
         default:   next_phase = PH_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         phase <= PH_IDLE;
      end else begin
         phase <= next_phase;
      end
   end

   // modulation index parity, loaded per symbol, flips per walk step
   always_ff @(posedge clk) begin
      if (reset) begin
         h_odd <= 1'b0;
      end else if (phase == PH_IDLE && sym_en) begin
         h_odd <= sym_even;
      end else if (phase inside {PH_ROW0, PH_ROW1, PH_ROW2}) begin
         h_odd <= ~h_odd;
      end
   end

   assign ctrl = '{phase: phase, h_odd: h_odd};

   // strobes must be spaced by the full walk
   a_strobe_in_idle: assert property (
      @(posedge clk) disable iff (reset) sym_en |-> phase == PH_IDLE
   ) else $error("sym_en during trace walk");

   // a walk only starts from an accepted strobe
   a_idle_holds: assert property (
      @(posedge clk) disable iff (reset)
      (phase == PH_IDLE && !sym_en) |=> phase == PH_IDLE
   ) else $error("phase left idle without sym_en");

endmodule

//--- rtl/trace_ctrl_pkg.sv
package trace_ctrl_pkg;

   // one clock per phase
   typedef enum logic [2:0] {
      PH_IDLE   = 3'd0,  // waiting for sym_en
      PH_ROW0   = 3'd1,  // walk through newest stored row
      PH_ROW1   = 3'd2,
      PH_ROW2   = 3'd3,  // oldest row
      PH_COMMIT = 3'd4   // decision out, history shift
   } trace_phase_t;

   // walk control broadcast by the sequencer
   typedef struct packed {
      trace_phase_t phase;
      logic         h_odd;  // high selects the 5 step
   } trace_ctrl_t;

endpackage

//--- rtl/trellis_pkg.sv
`include "trellis_config.svh"

package trellis_pkg;

   // one trellis state number
   typedef logic [`STATE_BITS-1:0] state_idx_t;

   // survivor selection, also the committed decision
   typedef logic [`DEC_BITS-1:0] branch_dec_t;

   // selections of every state for one symbol, element i is state i
   typedef branch_dec_t [`TRELLIS_STATES-1:0] survivor_row_t;

endpackage

//--- rtl/trellis_config.svh
`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// ------------------------------------------------------------
// trellis shape
// ------------------------------------------------------------
`define TRELLIS_STATES 64
`define STATE_BITS     6   // log2 of the state count
`define DEC_BITS       2   // quaternary branch decision

// ------------------------------------------------------------
// trace-back walk
// ------------------------------------------------------------
`define TB_DEPTH       3   // history rows walked per symbol
`define H_STEP_EVEN    4   // high nibble step, parity low
`define H_STEP_ODD     5   // high nibble step, parity high

`endif
